//--- vlog.f
rtl/rng_pkg.sv
rtl/lfsr32.sv
rtl/slowdown_timer.sv
rtl/draw_control.sv
rtl/value_register.sv
rtl/seven_seg.sv
rtl/rng_top.sv
test/rng_top_properties.sv
test/tb_rng_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_rng_top -f vlog.f -o tb_rng_top

./obj_dir/tb_rng_top +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
	exit 0
fi
exit 1

//--- test/tb_rng_top.sv
`timescale 1ns/10ps

module tb_rng_top;

	localparam int STEP = 3;
	localparam int T_MAX = 120;
	// reset, three draws with their idle gaps, pause and recall, in cycles
	localparam int RUN_CYC = 16 + 20 + 3 * (T_MAX + 20) + 20 + 20;

	logic i_clk = 0;
	logic i_rst_n = 0;
	logic i_start = 0;
	logic i_recall = 0;
	logic [3:0] o_value;
	logic [6:0] o_hex;
	logic o_busy;
	logic o_tick;
	logic pend = 0;
	int cyc = 0;
	int errs = 0;
	int t_errs = 0;
	int tests = 0;
	// start, pause and resume cycles and the cycle busy fell
	int s, q, r, fall;
	int unsigned lcg_state = 92583;
	int tick_cyc[$];
	logic [3:0] tick_val[$];
	logic [3:0] first_vals[$];

	rng_top #(.STEP(STEP), .T_MAX(T_MAX)) dut0 (.*);

	always #10 i_clk = ~i_clk;
	always @(posedge i_clk) cyc <= cyc + 1;
	always @(negedge i_clk) begin
		if (pend) tick_val.push_back(o_value);
		pend = o_tick;
		if (o_tick) tick_cyc.push_back(cyc);
	end

	// 20 ns per cycle plus 20 percent
	initial begin
		#(RUN_CYC * 24);
		$display("watchdog: the run did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// cycle of running count m once the paused cycles are left out
	function automatic int map_cycle(int m, bit paused);
		if (!paused || m <= q - s - 1) return s + 1 + m;
		return r + 1 + m - (q - s);
	endfunction

	task automatic step(int n);
		repeat (n) @(posedge i_clk);
		#2;
	endtask

	task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
		assert (exp === act) else begin
			$display("FAIL %s expected %0d actual %0d", name, exp, act);
			errs++;
		end
	endtask

	task automatic press_start();
		i_start = 1;
		step(1);
		i_start = 0;
	endtask

	task automatic press_recall();
		i_recall = 1;
		step(1);
		i_recall = 0;
	endtask

	task automatic wait_idle();
		for (int i = 0; i < 2 * T_MAX; i++) begin
			@(negedge i_clk);
			if (!o_busy) begin
				fall = cyc;
				return;
			end
		end
		$display("busy never fell after the draw");
		errs++;
	endtask

	// compare the recorded ticks and the busy fall with the schedule
	task automatic check_schedule(string name, bit paused);
		int pt = STEP;
		int per = STEP;
		int k = 0;
		while (pt <= T_MAX + 1) begin
			check_val({name, " tick cycle"}, map_cycle(pt, paused), tick_cyc[k]);
			k++;
			// the gap after the k-th tick is k times STEP
			pt += per;
			per += STEP;
		end
		check_val({name, " tick count"}, k, tick_cyc.size());
		check_val({name, " busy fall"}, map_cycle(T_MAX + 1, paused) + 1, fall);
	endtask

	task automatic finish_test(string name);
		tests++;
		$display("test %s done, %0d errors", name, errs - t_errs);
		t_errs = errs;
	endtask

	task automatic fresh_draw(string name);
		tick_cyc.delete();
		tick_val.delete();
		s = cyc;
		press_start();
		wait_idle();
		check_val({name, " latency"}, T_MAX + 3, fall - s);
		check_schedule(name, 0);
		step(2);
	endtask

	initial begin
		logic [3:0] v_start, v_end, v_hold;
		int diffs;
		step(16);
		i_rst_n = 1;
		step(2);
		check_val("reset busy", 0, o_busy);
		check_val("reset tick", 0, o_tick);
		check_val("reset value", 0, o_value);
		press_recall();
		step(1);
		check_val("early recall", 0, o_value);
		finish_test("reset");

		fresh_draw("uninterrupted");
		first_vals = tick_val;
		finish_test("uninterrupted");

		tick_cyc.delete();
		s = cyc;
		v_start = o_value;
		press_start();
		step(5 + lcg_next() % 50 - 1);
		q = cyc;
		press_start();
		@(negedge i_clk);
		check_val("pause busy", 0, o_busy);
		v_hold = o_value;
		repeat (3 + lcg_next() % 10) begin
			@(negedge i_clk);
			check_val("pause hold", v_hold, o_value);
		end
		step(1);
		r = cyc;
		press_start();
		wait_idle();
		check_schedule("pause resume", 1);
		// a restarted schedule would tick STEP running cycles after the resume
		foreach (tick_cyc[i]) begin
			assert (tick_cyc[i] <= q || tick_cyc[i] - (r + 1) > STEP) else begin
				$display("resumed draw restarted its schedule");
				errs++;
			end
		end
		finish_test("pause resume");

		step(2);
		v_end = o_value;
		press_recall();
		check_val("recall start", v_start, o_value);
		press_recall();
		check_val("recall end", v_end, o_value);
		finish_test("recall");

		fresh_draw("second draw");
		diffs = 0;
		foreach (tick_val[i]) begin
			if (i < first_vals.size() && tick_val[i] != first_vals[i]) begin
				diffs++;
			end
		end
		assert (diffs > 0) else begin
			$display("two fresh draws gave the same values, the seed did not move on");
			errs++;
		end
		finish_test("seed");

		errs += dut0.u_props.fail_count;
		finish_test("hex and timing");
		$display("%0d tests, %0d errors", tests, errs);
		if (errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- test/rng_top_properties.sv
`timescale 1ns/10ps

module rng_top_properties (
	input logic                        i_clk,
	input logic                        i_rst_n,
	input logic                        i_start,
	input logic                        i_recall,
	input logic [rng_pkg::VALUE_W-1:0] i_value,
	input logic [rng_pkg::SEG_W-1:0]   i_hex,
	input logic                        i_busy,
	input logic                        i_tick,
	input rng_pkg::draw_state_t        i_state
);

	int unsigned fail_count = 0;

	// active-high glyph table with segment a in bit 0
	function automatic logic [6:0] glyph(input logic [3:0] v);
		logic [6:0] lit [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
			7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
		return ~lit[v];
	endfunction

	a_hex: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_hex == glyph(i_value))
	else begin
		fail_count++;
		$error("segment pattern does not match the value");
	end

	a_value_cause: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!$stable(i_value) |-> $past(i_tick) || $past(i_recall))
	else begin
		fail_count++;
		$error("value changed without a tick or recall");
	end

	a_tick_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_tick |=> !i_tick)
	else begin
		fail_count++;
		$error("tick lasted longer than one cycle");
	end

	a_busy_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_start && !i_busy |=> i_busy)
	else begin
		fail_count++;
		$error("busy did not rise after start");
	end

	a_busy_fall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_start && i_busy |=> !i_busy)
	else begin
		fail_count++;
		$error("busy did not fall after pause");
	end

	// only a recall press may change the shown value during a pause
	a_pause_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_state == rng_pkg::S_PAUSE && !i_recall |=> $stable(i_value))
	else begin
		fail_count++;
		$error("value changed while the draw was paused");
	end

endmodule

bind rng_top rng_top_properties u_props (
	.i_clk   (i_clk),
	.i_rst_n (i_rst_n),
	.i_start (i_start),
	.i_recall(i_recall),
	.i_value (o_value),
	.i_hex   (o_hex),
	.i_busy  (o_busy),
	.i_tick  (o_tick),
	.i_state (u_draw_control.state_r)
);

//--- rtl/rng_top.sv
`timescale 1ns/10ps

module rng_top #(
	parameter int unsigned STEP  = 1_000_000,
	parameter int unsigned T_MAX = 500_000_000
) (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_start,
	input  logic                        i_recall,
	output logic [rng_pkg::VALUE_W-1:0] o_value,
	output logic [rng_pkg::SEG_W-1:0]   o_hex,
	output logic                        o_busy,
	output logic                        o_tick
);

	logic                       run_en;
	logic                       fresh;
	logic [rng_pkg::LFSR_W-1:0] seed;
	logic                       recall_en;
	logic                       timeout;
	logic [rng_pkg::LFSR_W-1:0] lfsr_state;

	draw_control #(
		.T_MAX(T_MAX)
	) u_draw_control (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_timeout   (timeout),
		.o_run       (run_en),
		.o_fresh     (fresh),
		.o_seed      (seed),
		.o_recall_en (recall_en),
		.o_busy      (o_busy)
	);

	slowdown_timer #(
		.STEP (STEP),
		.T_MAX(T_MAX)
	) u_slowdown_timer (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_clear   (fresh),
		.i_run     (run_en),
		.o_tick    (o_tick),
		.o_timeout (timeout)
	);

	// runs only in S_RUN, so a pause freezes the sequence too
	lfsr32 u_lfsr32 (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_load    (fresh),
		.i_seed    (seed),
		.i_advance (run_en),
		.o_state   (lfsr_state)
	);

	value_register u_value_register (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_capture   (fresh),
		.i_load      (o_tick),
		.i_sample    (lfsr_state[rng_pkg::VALUE_W-1:0]),
		.i_recall    (i_recall),
		.i_recall_en (recall_en),
		.o_value     (o_value)
	);

	seven_seg u_seven_seg (
		.i_value (o_value),
		.o_seg   (o_hex)
	);

endmodule

//--- rtl/seven_seg.sv
`timescale 1ns/10ps

module seven_seg (
	input  logic [rng_pkg::VALUE_W-1:0] i_value,
	output logic [rng_pkg::SEG_W-1:0]   o_seg
);

	// bit 6 is segment g, bit 0 is segment a, low lights the segment
	always_comb begin
		case (i_value)
			4'h0:    o_seg = 7'b1000000;
			4'h1:    o_seg = 7'b1111001;
			4'h2:    o_seg = 7'b0100100;
			4'h3:    o_seg = 7'b0110000;
			4'h4:    o_seg = 7'b0011001;
			4'h5:    o_seg = 7'b0010010;
			4'h6:    o_seg = 7'b0000010;
			4'h7:    o_seg = 7'b1111000;
			4'h8:    o_seg = 7'b0000000;
			4'h9:    o_seg = 7'b0010000;
			4'ha:    o_seg = 7'b0001000;
			// lower case b and d so they differ from 8 and 0
			4'hb:    o_seg = 7'b0000011;
			4'hc:    o_seg = 7'b1000110;
			4'hd:    o_seg = 7'b0100001;
			4'he:    o_seg = 7'b0000110;
			default: o_seg = 7'b0001110;
		endcase
	end

endmodule

//--- rtl/value_register.sv
`timescale 1ns/10ps

module value_register (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_capture,
	input  logic                        i_load,
	input  logic [rng_pkg::VALUE_W-1:0] i_sample,
	input  logic                        i_recall,
	input  logic                        i_recall_en,
	output logic [rng_pkg::VALUE_W-1:0] o_value
);

	logic [rng_pkg::VALUE_W-1:0] value_r;
	// value shown when the last draw began
	logic [rng_pkg::VALUE_W-1:0] mem_r;
	// present value parked while memory is on display
	logic [rng_pkg::VALUE_W-1:0] now_r;
	logic                        show_mem_r;

	// control and shown value
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			value_r    <= '0;
			show_mem_r <= 1'b0;
		end else if (i_capture) begin
			show_mem_r <= 1'b0;
		end else if (i_load) begin
			value_r <= i_sample;
		end else if (i_recall && i_recall_en) begin
			value_r    <= show_mem_r ? now_r : mem_r;
			show_mem_r <= !show_mem_r;
		end
	end

	// stored values, no reset
	always_ff @(posedge i_clk) begin
		if (i_capture) begin
			mem_r <= value_r;
		end else if (!i_load && i_recall && i_recall_en && !show_mem_r) begin
			now_r <= value_r;
		end
	end

	assign o_value = value_r;

endmodule

//--- rtl/draw_control.sv
`timescale 1ns/10ps

module draw_control #(
	parameter int unsigned T_MAX = 500_000_000
) (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  logic                       i_start,
	input  logic                       i_timeout,
	output logic                       o_run,
	output logic                       o_fresh,
	output logic [rng_pkg::LFSR_W-1:0] o_seed,
	output logic                       o_recall_en,
	output logic                       o_busy
);

	rng_pkg::draw_state_t state_r;
	rng_pkg::draw_state_t state_w;

	logic [rng_pkg::LFSR_W-1:0] seed_r;
	logic                       armed_r;
	logic                       fresh;
	logic                       stop;

	// a draw needs at least one running cycle before it can time out
	if (T_MAX < 1) begin : g_tmax_check
		$error("draw_control: T_MAX must be at least 1");
	end

	// start from idle is a new draw, start from pause is a resume
	assign fresh = (state_r == rng_pkg::S_IDLE) && i_start;

	// draw leaves S_RUN by pause or timeout
	assign stop = (state_r == rng_pkg::S_RUN) && (i_start || i_timeout);

	always_comb begin
		state_w = state_r;
		case (state_r)
			rng_pkg::S_IDLE: begin
				if (i_start) begin
					state_w = rng_pkg::S_RUN;
				end
			end
			rng_pkg::S_RUN: begin
				if (i_start) begin
					state_w = rng_pkg::S_PAUSE;
				end else if (i_timeout) begin
					state_w = rng_pkg::S_IDLE;
				end
			end
			rng_pkg::S_PAUSE: begin
				if (i_start) begin
					state_w = rng_pkg::S_RUN;
				end
			end
			default: state_w = rng_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= rng_pkg::S_IDLE;
			seed_r  <= rng_pkg::RESET_SEED;
			armed_r <= 1'b0;
		end else begin
			state_r <= state_w;
			// seed moves on only for a new draw
			if (fresh) begin
				seed_r <= {seed_r[rng_pkg::LFSR_W-4:0], 3'b101};
			end
			// recall has something to show once a draw has stopped
			if (stop) begin
				armed_r <= 1'b1;
			end
		end
	end

	assign o_run       = (state_r == rng_pkg::S_RUN);
	assign o_busy      = (state_r == rng_pkg::S_RUN);
	assign o_fresh     = fresh;
	assign o_seed      = seed_r;
	assign o_recall_en = armed_r && (state_r != rng_pkg::S_RUN);

endmodule

//--- rtl/slowdown_timer.sv
`timescale 1ns/10ps

module slowdown_timer #(
	parameter int unsigned STEP  = 1_000_000,
	parameter int unsigned T_MAX = 500_000_000
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_clear,
	input  logic i_run,
	output logic o_tick,
	output logic o_timeout
);

	localparam logic [rng_pkg::COUNT_W-1:0] STEP_C = rng_pkg::COUNT_W'(STEP);
	localparam logic [rng_pkg::COUNT_W-1:0] TMAX_C = rng_pkg::COUNT_W'(T_MAX);

	// cycles spent running in this draw
	logic [rng_pkg::COUNT_W-1:0] count_r;
	// gap to the sample point after next
	logic [rng_pkg::COUNT_W-1:0] period_r;
	// count value of the next sample point
	logic [rng_pkg::COUNT_W-1:0] next_r;

	logic tick;

	assign tick = i_run && (count_r == next_r);

	// the gap grows by STEP after every sample
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			count_r  <= '0;
			period_r <= STEP_C;
			next_r   <= STEP_C;
		end else if (i_clear) begin
			count_r  <= '0;
			period_r <= STEP_C;
			next_r   <= STEP_C;
		end else if (i_run) begin
			count_r <= count_r + 1'b1;
			if (tick) begin
				next_r   <= next_r + period_r;
				period_r <= period_r + STEP_C;
			end
		end
		// not running: everything holds so a resume picks up the schedule
	end

	assign o_tick = tick;

	// stays high after the draw ends until the next clear
	assign o_timeout = (count_r > TMAX_C);

endmodule

//--- rtl/lfsr32.sv
`timescale 1ns/10ps

module lfsr32 (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  logic                       i_load,
	input  logic [rng_pkg::LFSR_W-1:0] i_seed,
	input  logic                       i_advance,
	output logic [rng_pkg::LFSR_W-1:0] o_state
);

	logic [rng_pkg::LFSR_W-1:0] state_r;
	logic [2:0]                 fb;

	// three new bits per clock, each from four taps
	assign fb[2] = state_r[31] ^ state_r[30] ^ state_r[24] ^ state_r[10];
	assign fb[1] = state_r[31] ^ state_r[29] ^ state_r[23] ^ state_r[9];
	assign fb[0] = state_r[27] ^ state_r[22] ^ state_r[21] ^ state_r[4];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= '0;
		end else if (i_load) begin
			state_r <= i_seed;
		end else if (i_advance) begin
			state_r <= {state_r[rng_pkg::LFSR_W-4:0], fb};
		end
	end

	assign o_state = state_r;

endmodule

//--- rtl/rng_pkg.sv
package rng_pkg;

	// width of the shown value, one hex digit
	parameter int VALUE_W = 4;

	// LFSR and seed register width
	parameter int LFSR_W = 32;

	// draw counter, period and next sample point
	parameter int COUNT_W = 32;

	// segment pattern a..g, bit 0 is segment a
	parameter int SEG_W = 7;

	// seed loaded at reset
	parameter logic [LFSR_W-1:0] RESET_SEED = 32'h0F4A_7C15;

	// paused counts as idle for recall
	typedef enum logic [1:0] {
		S_IDLE  = 2'd0,
		S_RUN   = 2'd1,
		S_PAUSE = 2'd2
	} draw_state_t;

endpackage
